/* sample_pkg.sv */
`default_nettype none

package sample_pkg;

  // sample path width.
  localparam int SAMPLE_W = 16;

  // storage depth and pointer width, depth is a power of two.
  localparam int FIFO_DEPTH = 32;
  localparam int PTR_W      = 5;

  // occupancy thresholds.
  localparam int AF_LEVEL = 28;  // almost_full at or above.
  localparam int AE_LEVEL = 4;   // almost_empty at or below.

  // one sample.
  typedef logic [SAMPLE_W-1:0] sample_t;

  // occupancy, 0 to FIFO_DEPTH inclusive.
  typedef logic [PTR_W:0] level_t;

  // saturating count of refused samples.
  typedef logic [15:0] drop_cnt_t;

  // completed bursts, wraps.
  typedef logic [7:0] burst_cnt_t;

  // fifo occupancy and flags.
  typedef struct packed {
    level_t level;
    logic   empty;
    logic   full;
    logic   almost_empty;
    logic   almost_full;
  } fifo_status_t;

  // one output beat.
  typedef struct packed {
    logic    valid;
    sample_t data;
  } out_beat_t;

  // drain controller states.
  typedef enum logic [0:0] {
    DRAIN_IDLE  = 1'b0,
    DRAIN_BURST = 1'b1
  } drain_state_e;

endpackage

`default_nettype wire

/* sample_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module sample_fifo (
  input  logic                      CLK,
  input  logic                      RESETN,
  input  logic                      wr_en,
  input  sample_pkg::sample_t       wr_data,
  input  logic                      rd_en,
  output sample_pkg::sample_t       rd_data,
  output sample_pkg::fifo_status_t  status
);

  sample_pkg::sample_t            mem [sample_pkg::FIFO_DEPTH];
  logic [sample_pkg::PTR_W-1:0]   wr_ptr;
  logic [sample_pkg::PTR_W-1:0]   rd_ptr;
  sample_pkg::level_t             level;

  // storage, no reset on the payload.
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // write pointer wraps at the depth.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // occupancy register.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      level <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // idle or both.
      endcase
    end
  end

  // first word fall through.
  assign rd_data = mem[rd_ptr];

  // flags come from the count, not from the pointers.
  always_comb begin
    status.level        = level;
    status.empty        = (level == '0);
    status.full         = (level == sample_pkg::level_t'(sample_pkg::FIFO_DEPTH));
    status.almost_empty = (level <= sample_pkg::level_t'(sample_pkg::AE_LEVEL));
    status.almost_full  = (level >= sample_pkg::level_t'(sample_pkg::AF_LEVEL));
  end

endmodule

`default_nettype wire

/* ingress_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module ingress_ctrl (
  input  logic                    CLK,
  input  logic                    RESETN,
  input  logic                    in_valid,
  input  sample_pkg::sample_t     in_data,
  input  logic                    full,
  input  logic                    clear_overflow,
  output logic                    wr_en,
  output sample_pkg::sample_t     wr_data,
  output sample_pkg::drop_cnt_t   drop_count,
  output logic                    overflow
);

  logic drop;

  // accept unless the fifo is full.
  assign wr_en   = in_valid & ~full;
  assign wr_data = in_data;
  assign drop    = in_valid & full;

  // refused samples, holds at the top value.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  // sticky flag.
  // a drop in the same cycle as the clear keeps it set.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      overflow <= 1'b0;
    end else if (drop) begin
      overflow <= 1'b1;
    end else if (clear_overflow) begin
      overflow <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* burst_drain.sv */
`default_nettype none
`timescale 1ns/1ps

module burst_drain (
  input  logic                      CLK,
  input  logic                      RESETN,
  input  sample_pkg::fifo_status_t  status,
  input  sample_pkg::sample_t       rd_data,
  input  logic                      out_stall,
  output logic                      rd_en,
  output sample_pkg::out_beat_t     out_beat,
  output sample_pkg::burst_cnt_t    burst_count
);

  sample_pkg::drain_state_e  state;
  sample_pkg::drain_state_e  state_nxt;
  sample_pkg::level_t        level_after;
  logic                      burst_done;

  // read whenever bursting, not stalled and not empty.
  assign rd_en = (state == sample_pkg::DRAIN_BURST) & ~out_stall & ~status.empty;

  assign out_beat.valid = rd_en;
  assign out_beat.data  = rd_data;

  // occupancy once this read is taken.
  assign level_after = status.level - 1'b1;

  // burst ends on the read that reaches the low mark, or on empty.
  assign burst_done = (state == sample_pkg::DRAIN_BURST) &
                      ((rd_en & (level_after <= sample_pkg::level_t'(sample_pkg::AE_LEVEL))) |
                       status.empty);

  always_comb begin
    state_nxt = state;
    case (state)
      sample_pkg::DRAIN_IDLE: begin
        if (status.almost_full) begin
          state_nxt = sample_pkg::DRAIN_BURST;
        end
      end
      sample_pkg::DRAIN_BURST: begin
        if (burst_done) begin
          state_nxt = sample_pkg::DRAIN_IDLE;
        end
      end
      default: state_nxt = sample_pkg::DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= sample_pkg::DRAIN_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // wraps.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      burst_count <= '0;
    end else if (burst_done) begin
      burst_count <= burst_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sample_buffer_top.sv */
`default_nettype none
`timescale 1ns/1ps

module sample_buffer_top (
  input  logic                      CLK,
  input  logic                      RESETN,
  input  logic                      in_valid,
  input  sample_pkg::sample_t       in_data,
  input  logic                      clear_overflow,
  input  logic                      out_stall,
  output sample_pkg::out_beat_t     out_beat,
  output sample_pkg::fifo_status_t  status,
  output sample_pkg::drop_cnt_t     drop_count,
  output logic                      overflow,
  output sample_pkg::burst_cnt_t    burst_count
);

  logic                 wr_en;
  sample_pkg::sample_t  wr_data;
  logic                 rd_en;
  sample_pkg::sample_t  rd_data;

  ingress_ctrl u_ingress (
    .CLK            (CLK),
    .RESETN         (RESETN),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .full           (status.full),
    .clear_overflow (clear_overflow),
    .wr_en          (wr_en),
    .wr_data        (wr_data),
    .drop_count     (drop_count),
    .overflow       (overflow)
  );

  // strobes arrive already guarded.
  sample_fifo u_fifo (
    .CLK     (CLK),
    .RESETN  (RESETN),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .status  (status)
  );

  burst_drain u_drain (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .status      (status),
    .rd_data     (rd_data),
    .out_stall   (out_stall),
    .rd_en       (rd_en),
    .out_beat    (out_beat),
    .burst_count (burst_count)
  );

endmodule

`default_nettype wire

/* tb_props.sv */
`default_nettype none
`timescale 1ns/1ps

module sample_fifo_props (
  input logic                          CLK,
  input logic                          RESETN,
  input logic                          wr_en,
  input logic                          rd_en,
  input logic [sample_pkg::PTR_W-1:0]  wr_ptr,
  input logic [sample_pkg::PTR_W-1:0]  rd_ptr,
  input sample_pkg::fifo_status_t      status
);

  level_in_range: assert property (@(posedge CLK) disable iff (!RESETN)
    status.level <= sample_pkg::level_t'(sample_pkg::FIFO_DEPTH))
    else $error("fifo level %0d above depth", status.level);

  // occupancy agrees with the pointer distance.
  level_matches_ptrs: assert property (@(posedge CLK) disable iff (!RESETN)
    status.level[sample_pkg::PTR_W-1:0] == (wr_ptr - rd_ptr))
    else $error("level %0d against write pointer %0d and read pointer %0d",
                status.level, wr_ptr, rd_ptr);

  // strobes are guarded outside the fifo.
  no_write_when_full: assert property (@(posedge CLK) disable iff (!RESETN)
    !(wr_en && status.full))
    else $error("write strobe while fifo full");

  no_read_when_empty: assert property (@(posedge CLK) disable iff (!RESETN)
    !(rd_en && status.empty))
    else $error("read strobe while fifo empty");

endmodule

bind sample_fifo sample_fifo_props u_props (
  .CLK    (CLK),
  .RESETN (RESETN),
  .wr_en  (wr_en),
  .rd_en  (rd_en),
  .wr_ptr (wr_ptr),
  .rd_ptr (rd_ptr),
  .status (status)
);

`default_nettype wire

/* tb.sv */
`default_nettype none
`timescale 1ns/1ps

module tb;

  // one row of the scenario table.
  typedef struct packed {
    int unsigned samples;
    int unsigned wr_pct;
    int unsigned stall_pct;
    bit          clear;
    int unsigned settle;
  } scenario_t;

  // samples, write %, stall %, clear overflow, settle cycles.
  scenario_t rows [6] = '{
    '{32'd20, 32'd100, 32'd0,   1'b0, 32'd20},  // fills below the high mark.
    '{32'd60, 32'd70,  32'd0,   1'b0, 32'd40},
    '{32'd48, 32'd100, 32'd100, 1'b0, 32'd20},  // held back until it overflows.
    '{32'd0,  32'd0,   32'd100, 1'b1, 32'd10},
    '{32'd80, 32'd90,  32'd30,  1'b0, 32'd80},
    '{32'd70, 32'd60,  32'd50,  1'b1, 32'd60}
  };

  logic                      CLK;
  logic                      RESETN;
  logic                      in_valid;
  sample_pkg::sample_t       in_data;
  logic                      clear_overflow;
  logic                      out_stall;
  sample_pkg::out_beat_t     out_beat;
  sample_pkg::fifo_status_t  status;
  sample_pkg::drop_cnt_t     drop_count;
  logic                      overflow;
  sample_pkg::burst_cnt_t    burst_count;

  // reference model.
  sample_pkg::sample_t       model_q [$];
  sample_pkg::drain_state_e  m_state;
  int unsigned               m_drops;
  int unsigned               m_bursts;
  logic                      m_ovf;
  logic                      af_seen;
  bit                        last_wr;
  sample_pkg::burst_cnt_t    prev_bursts;
  int unsigned               beats;
  int unsigned               strobes;
  int unsigned               errors;

  sample_buffer_top DUT (
    .CLK            (CLK),
    .RESETN         (RESETN),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .clear_overflow (clear_overflow),
    .out_stall      (out_stall),
    .out_beat       (out_beat),
    .status         (status),
    .drop_count     (drop_count),
    .overflow       (overflow),
    .burst_count    (burst_count)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  function automatic bit chance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  // one clock of stimulus.
  task automatic drive_cycle(input logic valid, input int unsigned stall_pct);
    @(posedge CLK);
    in_valid       <= valid;
    in_data        <= sample_pkg::sample_t'($urandom);
    out_stall      <= chance(stall_pct);
    clear_overflow <= 1'b0;
  endtask

  // clear pulse with no write around it.
  task automatic pulse_clear(input int unsigned stall_pct);
    sample_pkg::drop_cnt_t drops_before;
    drive_cycle(1'b0, stall_pct);
    @(negedge CLK);
    drops_before = drop_count;
    @(posedge CLK);
    in_valid       <= 1'b0;
    clear_overflow <= 1'b1;
    out_stall      <= chance(stall_pct);
    drive_cycle(1'b0, stall_pct);
    @(negedge CLK);
    if (overflow !== 1'b0) begin
      flag_mismatch("overflow still set after clear_overflow");
    end
    if (drop_count !== drops_before) begin
      flag_mismatch($sformatf("drop_count %0d changed by clear, was %0d",
                              drop_count, drops_before));
    end
  endtask

  task automatic check_reset_values();
    if (out_beat.valid !== 1'b0 || overflow !== 1'b0) begin
      flag_mismatch("beat valid or overflow high after reset");
    end
    if (drop_count !== '0 || burst_count !== '0) begin
      flag_mismatch("counts not zero after reset");
    end
    if (status.level !== '0 || status.empty !== 1'b1 || status.almost_empty !== 1'b1) begin
      flag_mismatch("fifo status not empty after reset");
    end
    if (DUT.u_drain.state !== sample_pkg::DRAIN_IDLE) begin
      flag_mismatch("drain FSM not idle after reset");
    end
  endtask

  // model steps at the falling edge for the rising edge that follows.
  always @(negedge CLK) begin : model_step
    bit rd;
    bit wr;
    bit drop;
    bit done;
    if (!RESETN) begin
      model_q.delete();
      m_state     = sample_pkg::DRAIN_IDLE;
      m_drops     = 0;
      m_bursts    = 0;
      m_ovf       = 1'b0;
      af_seen     = 1'b0;
      last_wr     = 1'b0;
      prev_bursts = '0;
    end else begin
      wr   = in_valid && (model_q.size() < sample_pkg::FIFO_DEPTH);
      drop = in_valid && (model_q.size() == sample_pkg::FIFO_DEPTH);
      rd   = (m_state == sample_pkg::DRAIN_BURST) && !out_stall && (model_q.size() != 0);
      if (status.level !== sample_pkg::level_t'(model_q.size())) begin
        flag_mismatch($sformatf("level %0d, expected %0d", status.level, model_q.size()));
      end
      if (status.empty !== (model_q.size() == 0) ||
          status.full !== (model_q.size() == sample_pkg::FIFO_DEPTH) ||
          status.almost_empty !== (model_q.size() <= sample_pkg::AE_LEVEL) ||
          status.almost_full !== (model_q.size() >= sample_pkg::AF_LEVEL)) begin
        flag_mismatch($sformatf("flags e%b f%b ae%b af%b at expected level %0d",
                                status.empty, status.full, status.almost_empty,
                                status.almost_full, model_q.size()));
      end
      if (out_beat.valid !== rd) begin
        flag_mismatch($sformatf("beat valid %b, expected %b", out_beat.valid, rd));
      end
      if (rd && out_beat.data !== model_q[0]) begin
        flag_mismatch($sformatf("beat data %h, expected %h", out_beat.data, model_q[0]));
      end
      if (drop_count !== sample_pkg::drop_cnt_t'(m_drops) || overflow !== m_ovf) begin
        flag_mismatch($sformatf("drops %0d ovf %b, expected %0d %b",
                                drop_count, overflow, m_drops, m_ovf));
      end
      if (burst_count !== sample_pkg::burst_cnt_t'(m_bursts)) begin
        flag_mismatch($sformatf("bursts %0d, expected %0d", burst_count, m_bursts));
      end
      if (beats + status.level + drop_count != strobes) begin
        flag_mismatch($sformatf("%0d beats + level + drops, %0d strobes", beats, strobes));
      end
      // burst boundaries seen from the outside.
      if (burst_count !== prev_bursts) begin
        // a write on the closing edge is not part of the burst.
        if (status.level - sample_pkg::level_t'(last_wr) >
            sample_pkg::level_t'(sample_pkg::AE_LEVEL)) begin
          flag_mismatch($sformatf("burst ended at level %0d", status.level));
        end
        af_seen = 1'b0;
      end
      prev_bursts = burst_count;
      if (status.level >= sample_pkg::level_t'(sample_pkg::AF_LEVEL)) begin
        af_seen = 1'b1;
      end
      if (out_beat.valid === 1'b1 && !af_seen) begin
        flag_mismatch("beat before the fifo reached almost full");
      end
      done = (m_state == sample_pkg::DRAIN_BURST) &&
             ((rd && (model_q.size() - 1 <= sample_pkg::AE_LEVEL)) || (model_q.size() == 0));
      if (m_state == sample_pkg::DRAIN_IDLE && model_q.size() >= sample_pkg::AF_LEVEL) begin
        m_state = sample_pkg::DRAIN_BURST;
      end else if (done) begin
        m_state = sample_pkg::DRAIN_IDLE;
        m_bursts++;
      end
      if (rd) begin
        void'(model_q.pop_front());
      end
      if (wr) begin
        model_q.push_back(in_data);
      end
      if (drop && m_drops < 65535) begin
        m_drops++;
      end
      if (drop) begin
        m_ovf = 1'b1;
      end else if (clear_overflow) begin
        m_ovf = 1'b0;
      end
      last_wr = wr;
      if (in_valid) strobes++;
      if (out_beat.valid === 1'b1) beats++;
    end
  end

  initial begin : stimulus
    int unsigned           gap;
    int unsigned           i;
    sample_pkg::drop_cnt_t drops_at_start;
    void'($urandom(85351));
    RESETN         = 1'b0;
    in_valid       = 1'b0;
    in_data        = '0;
    clear_overflow = 1'b0;
    out_stall      = 1'b0;
    beats          = 0;
    strobes        = 0;
    errors         = 0;
    repeat (4) @(posedge CLK);
    RESETN <= 1'b1;
    @(negedge CLK);
    check_reset_values();
    foreach (rows[r]) begin
      drops_at_start = drop_count;
      if (rows[r].clear) begin
        pulse_clear(rows[r].stall_pct);
      end
      for (i = 0; i < rows[r].samples; i++) begin
        gap = 0;
        while (gap < 2 && !chance(rows[r].wr_pct)) begin
          gap++;
        end
        repeat (gap) drive_cycle(1'b0, rows[r].stall_pct);
        drive_cycle(1'b1, rows[r].stall_pct);
      end
      repeat (rows[r].settle) drive_cycle(1'b0, rows[r].stall_pct);
      @(negedge CLK);
      // no reads at all, so anything past the depth is dropped.
      if (rows[r].stall_pct == 100 && rows[r].samples > sample_pkg::FIFO_DEPTH) begin
        if (overflow !== 1'b1) begin
          flag_mismatch($sformatf("overflow not set after stalled row %0d", r));
        end
        if (drop_count - drops_at_start < rows[r].samples - sample_pkg::FIFO_DEPTH) begin
          flag_mismatch($sformatf("only %0d drops in stalled row %0d",
                                  drop_count - drops_at_start, r));
        end
      end
    end
    $display("beats %0d, strobes %0d, drops %0d, bursts %0d, errors %0d",
             beats, strobes, drop_count, burst_count, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // four times the table length in cycles.
  initial begin : watchdog
    int unsigned budget;
    budget = 0;
    foreach (rows[r]) begin
      budget += rows[r].samples + rows[r].settle;
    end
    #(budget * 4 * 4);
    $display("timeout: scenario table still running after %0d ns", budget * 16);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
sample_pkg.sv
sample_fifo.sv
ingress_ctrl.sv
burst_drain.sv
sample_buffer_top.sv
tb_props.sv
tb.sv

/* Makefile */
# Verilator build and run of the sample buffer testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb -f tb.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
